/* logic/floo_flit_pkg.sv */
/*
 * floo flit package
 * head flit header format for the router switch allocator
 * and the output directions a lookahead route can name
 */

`default_nettype none

package floo_flit_pkg;

  // one header word, the fields below fill it exactly
  localparam int unsigned HdrLength = 8;

  // output direction of the next hop
  // eject hands the flit to the local endpoint
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  // destination id takes whatever is left after lookahead and last
  localparam int unsigned DstIdWidth = HdrLength - $bits(route_dir_e) - 1;

  // head flit header as seen by the allocator
  typedef struct packed {
    route_dir_e                lookahead;
    logic                      last;
    logic [DstIdWidth-1:0]     dst_id;
  } hdr_t;

endpackage

`default_nettype wire

/* logic/floo_sa_pkg.sv */
/*
 * floo switch allocator package
 * router sizes and the index widths derived from them
 */

`default_nettype none

package floo_sa_pkg;

  // virtual channels per input port
  localparam int unsigned NumVC = 4;

  // vc index, at least one bit even for a single vc
  localparam int unsigned NumVCWidth = (NumVC > 1) ? $clog2(NumVC) : 1;

  // router ports, one per route direction incl. eject
  localparam int unsigned NumPorts = 5;

  // port index
  localparam int unsigned NumPortsWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

endpackage

`default_nettype wire

/* logic/floo_rr_arbiter.sv */
/*
 * floo round-robin arbiter
 * grants the first request at or after a priority pointer, wrapping
 * around, as one-hot and as an index
 * the pointer moves past the grant only when update_i is set
 */

`timescale 1ns/1ns
`default_nettype none

module floo_rr_arbiter #(
  parameter int unsigned NumInputs = 4,
  parameter int unsigned IdxWidth  = (NumInputs > 1) ? $clog2(NumInputs) : 1
) (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic [NumInputs-1:0] req_i,
  input  wire logic                 update_i,
  output logic      [NumInputs-1:0] grant_o,
  output logic      [IdxWidth-1:0]  grant_id_o
);

  // index with the highest priority this cycle
  logic [IdxWidth-1:0] ptr_q;
  logic [IdxWidth-1:0] ptr_d;

  // walk from the pointer upwards and take the first request
  always_comb begin
    int unsigned idx;
    logic        found;
    grant_o    = '0;
    grant_id_o = '0;
    found      = 1'b0;
    for (int unsigned k = 0; k < NumInputs; k++) begin
      idx = int'(ptr_q) + k;
      // wrap without a modulo, idx stays below 2*NumInputs
      if (idx >= NumInputs) begin
        idx = idx - NumInputs;
      end
      if (!found && req_i[idx]) begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        grant_id_o   = IdxWidth'(idx);
      end
    end
  end

  // next pointer is one past the winner, wrapping at NumInputs
  always_comb begin
    ptr_d = ptr_q;
    if (update_i && (|grant_o)) begin
      if (grant_id_o == IdxWidth'(NumInputs - 1)) begin
        ptr_d = '0;
      end else begin
        ptr_d = grant_id_o + IdxWidth'(1);
      end
    end
  end

  // lowest index wins first after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

/* logic/floo_mux.sv */
/*
 * floo one-hot mux
 * and-or selection of one payload out of NumInputs
 * output is all zero when no select bit is set
 */

`timescale 1ns/1ns
`default_nettype none

module floo_mux #(
  parameter int unsigned NumInputs = 2,
  parameter type         payload_t = logic
) (
  input  wire logic     [NumInputs-1:0] sel_i,
  input  wire payload_t [NumInputs-1:0] data_i,
  output payload_t                      data_o
);

  localparam int unsigned Width = $bits(payload_t);

  // mask each input by its select bit and or them together
  always_comb begin
    logic [Width-1:0] acc;
    acc = '0;
    for (int unsigned i = 0; i < NumInputs; i++) begin
      acc = acc | ({Width{sel_i[i]}} & Width'(data_i[i]));
    end
    data_o = payload_t'(acc);
  end

endmodule

`default_nettype wire

/* logic/floo_sa_if.sv */
/*
 * floo switch allocator link
 * one input port's chosen head going to the global stage
 * and the grant coming back for it
 */

`timescale 1ns/1ns
`default_nettype none

interface floo_sa_if;

  import floo_sa_pkg::*;

  // some vc of this input holds a head
  logic                  v;
  // vc picked by the local arbiter
  logic [NumVCWidth-1:0] vc_id;
  // requested output, one-hot, zero when idle
  logic [NumPorts-1:0]   dir_oh;
  // picked head closes its packet
  logic                  last;
  // granted and last, both arbiters move on this
  logic                  upd;
  // input won its output this cycle
  logic                  gnt;

  modport local_mp (
    output v,
    output vc_id,
    output dir_oh,
    output last,
    output upd,
    input  gnt
  );

  modport global_mp (
    input  v,
    input  dir_oh,
    input  upd,
    output gnt
  );

endinterface

`default_nettype wire

/* logic/floo_sa_local.sv */
/*
 * floo switch allocator, local stage
 * one per input port: picks a valid vc by round robin, selects its
 * header and turns the lookahead into a one-hot output request
 * the pointer only moves when the granted head is the last flit
 */

`timescale 1ns/1ns
`default_nettype none

module floo_sa_local (
  input  wire logic                                     clk_i,
  input  wire logic                                     arst_n_i,
  input  wire logic [floo_sa_pkg::NumVC-1:0]            vc_ctrl_head_v_i,
  input  wire floo_flit_pkg::hdr_t [floo_sa_pkg::NumVC-1:0] vc_ctrl_head_i,
  floo_sa_if.local_mp                                   sa
);

  import floo_flit_pkg::*;
  import floo_sa_pkg::*;

  // one-hot vc choice and the header it points at
  logic [NumVC-1:0] vc_gnt_oh;
  hdr_t             sel_head;

  // round robin over the valid vcs
  // a blocked vc keeps winning since the pointer holds
  floo_rr_arbiter #(
    .NumInputs  (NumVC)
  ) i_vc_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (vc_ctrl_head_v_i),
    .update_i   (sa.upd),
    .grant_o    (vc_gnt_oh),
    .grant_id_o (sa.vc_id)
  );

  floo_mux #(
    .NumInputs (NumVC),
    .payload_t (hdr_t)
  ) i_head_mux (
    .sel_i     (vc_gnt_oh),
    .data_i    (vc_ctrl_head_i),
    .data_o    (sel_head)
  );

  // any valid vc means a vc is chosen
  assign sa.v    = |vc_ctrl_head_v_i;
  assign sa.last = sel_head.last;

  // lookahead to one-hot direction, nothing requested when idle
  always_comb begin
    for (int unsigned p = 0; p < NumPorts; p++) begin
      sa.dir_oh[p] = sa.v && (sel_head.lookahead == route_dir_e'(p));
    end
  end

  // wormhole: move on only once the tail has gone through
  // the global stage reuses this for its own pointer
  assign sa.upd = sa.gnt & sa.last;

endmodule

`default_nettype wire

/* logic/floo_sa_global.sv */
/*
 * floo switch allocator, global stage
 * per output port: round robin among the inputs that request it,
 * masked by the output's ready level
 * grants go back per input, and each output pointer moves with the
 * update of the input it picked
 */

`timescale 1ns/1ns
`default_nettype none

module floo_sa_global (
  input  wire logic                                   clk_i,
  input  wire logic                                   arst_n_i,
  floo_sa_if.global_mp                                sa [floo_sa_pkg::NumPorts],
  input  wire logic [floo_sa_pkg::NumPorts-1:0]       out_ready_i,
  output logic      [floo_sa_pkg::NumPorts-1:0]       out_v_o,
  output logic      [floo_sa_pkg::NumPorts-1:0]
                    [floo_sa_pkg::NumPortsWidth-1:0]  out_sel_in_o
);

  import floo_sa_pkg::*;

  // per input, flattened out of the interface array
  logic [NumPorts-1:0]               in_v;
  logic [NumPorts-1:0][NumPorts-1:0] in_dir_oh;
  logic [NumPorts-1:0]               in_upd;
  logic [NumPorts-1:0]               in_gnt;

  // per output, indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0] out_req;
  logic [NumPorts-1:0][NumPorts-1:0] out_gnt_oh;
  logic [NumPorts-1:0]               out_upd;

  // interface array needs constant indices
  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    assign in_v[i]      = sa[i].v;
    assign in_dir_oh[i] = sa[i].dir_oh;
    assign in_upd[i]    = sa[i].upd;
    assign sa[i].gnt    = in_gnt[i];
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    // transpose: input i asks for output o
    // a not-ready output sees no request at all, so nothing moves
    for (genvar i = 0; i < NumPorts; i++) begin : gen_req
      assign out_req[o][i] = in_v[i] & in_dir_oh[i][o] & out_ready_i[o];
    end

    // advance only when the picked input sent its tail
    assign out_upd[o] = |(out_gnt_oh[o] & in_upd);

    floo_rr_arbiter #(
      .NumInputs  (NumPorts)
    ) i_out_arbiter (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_i      (out_req[o]),
      .update_i   (out_upd[o]),
      .grant_o    (out_gnt_oh[o]),
      .grant_id_o (out_sel_in_o[o])
    );

    assign out_v_o[o] = |out_gnt_oh[o];
  end

  // an input asks for one output at most, so an or over outputs
  // gives its grant
  always_comb begin
    in_gnt = '0;
    for (int unsigned o = 0; o < NumPorts; o++) begin
      in_gnt = in_gnt | out_gnt_oh[o];
    end
  end

endmodule

`default_nettype wire

/* logic/floo_switch_alloc.sv */
/*
 * floo switch allocator
 * separable two stage allocator for one vc router: a local vc
 * arbiter per input and a round-robin arbiter per output
 * purely combinational apart from the arbiter pointers
 */

`timescale 1ns/1ns
`default_nettype none

module floo_switch_alloc (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  // head flits per input port and vc
  input  wire logic [floo_sa_pkg::NumPorts-1:0]
                    [floo_sa_pkg::NumVC-1:0]              vc_head_v_i,
  input  wire floo_flit_pkg::hdr_t [floo_sa_pkg::NumPorts-1:0]
                    [floo_sa_pkg::NumVC-1:0]              vc_head_i,
  // back-pressure level per output port
  input  wire logic [floo_sa_pkg::NumPorts-1:0]           out_ready_i,
  // grant and granted vc per input port
  output logic      [floo_sa_pkg::NumPorts-1:0]           in_gnt_o,
  output logic      [floo_sa_pkg::NumPorts-1:0]
                    [floo_sa_pkg::NumVCWidth-1:0]         in_gnt_vc_id_o,
  // winner per output port
  output logic      [floo_sa_pkg::NumPorts-1:0]           out_v_o,
  output logic      [floo_sa_pkg::NumPorts-1:0]
                    [floo_sa_pkg::NumPortsWidth-1:0]      out_sel_in_o
);

  import floo_sa_pkg::*;

  // one link per input port between the two stages
  floo_sa_if sa_if [NumPorts] ();

  for (genvar i = 0; i < NumPorts; i++) begin : gen_local
    floo_sa_local i_sa_local (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .vc_ctrl_head_v_i (vc_head_v_i[i]),
      .vc_ctrl_head_i   (vc_head_i[i]),
      .sa               (sa_if[i])
    );

    assign in_gnt_o[i]       = sa_if[i].gnt;
    assign in_gnt_vc_id_o[i] = sa_if[i].vc_id;
  end

  floo_sa_global i_sa_global (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .sa           (sa_if),
    .out_ready_i  (out_ready_i),
    .out_v_o      (out_v_o),
    .out_sel_in_o (out_sel_in_o)
  );

endmodule

`default_nettype wire

/* bench/floo_switch_alloc_props.sv */
/*
 * floo switch allocator properties
 * grant consistency between the output and input sides, quiet
 * blocked outputs and idle grants right after reset
 */

`timescale 1ns/1ns
`default_nettype none

module floo_switch_alloc_props (
  input wire logic                                  clk_i,
  input wire logic                                  arst_n_i,
  input wire logic [floo_sa_pkg::NumPorts-1:0]      out_ready_i,
  input wire logic [floo_sa_pkg::NumPorts-1:0]      in_gnt_o,
  input wire logic [floo_sa_pkg::NumPorts-1:0]      out_v_o,
  input wire logic [floo_sa_pkg::NumPorts-1:0]
                   [floo_sa_pkg::NumPortsWidth-1:0] out_sel_in_o
);

  import floo_sa_pkg::*;

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    // the input an output picks must see its grant
    a_sel_granted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_v_o[o] |-> in_gnt_o[out_sel_in_o[o]])
      else $error("output %0d picks input %0d without a grant", o, out_sel_in_o[o]);

    // a blocked output selects nobody
    a_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !out_ready_i[o] |-> !out_v_o[o])
      else $error("output %0d valid while not ready", o);

    // two outputs never pick the same input
    for (genvar p = o + 1; p < NumPorts; p++) begin : gen_pair
      a_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(out_v_o[o] && out_v_o[p] && (out_sel_in_o[o] == out_sel_in_o[p])))
        else $error("outputs %0d and %0d grant the same input", o, p);
    end
  end

  // first cycle out of reset carries no grant
  a_reset_idle: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> ((in_gnt_o == '0) && (out_v_o == '0)))
    else $error("grant right after reset");

endmodule

bind floo_switch_alloc floo_switch_alloc_props i_floo_switch_alloc_props (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .out_ready_i  (out_ready_i),
  .in_gnt_o     (in_gnt_o),
  .out_v_o      (out_v_o),
  .out_sel_in_o (out_sel_in_o)
);

`default_nettype wire

/* bench/tb_floo_switch_alloc.sv */
/*
 * testbench for the floo switch allocator
 * directed and seeded random stimulus, every cycle checked against
 * a reference model that keeps its own local and global pointers
 */

`timescale 1ns/1ns
`default_nettype none

module tb_floo_switch_alloc;

  import floo_flit_pkg::*;
  import floo_sa_pkg::*;

  logic                                   clk_i;
  logic                                   arst_n_i;
  logic [NumPorts-1:0][NumVC-1:0]         vc_head_v_i;
  hdr_t [NumPorts-1:0][NumVC-1:0]         vc_head_i;
  logic [NumPorts-1:0]                    out_ready_i;
  logic [NumPorts-1:0]                    in_gnt_o;
  logic [NumPorts-1:0][NumVCWidth-1:0]    in_gnt_vc_id_o;
  logic [NumPorts-1:0]                    out_v_o;
  logic [NumPorts-1:0][NumPortsWidth-1:0] out_sel_in_o;

  // model pointers for each input vc arbiter and each output port arbiter
  int unsigned lptr [NumPorts];
  int unsigned gptr [NumPorts];
  // model results of the current cycle
  logic [NumPorts-1:0]                    exp_v;
  logic [NumPorts-1:0][NumVCWidth-1:0]    exp_vc;
  logic [NumPorts-1:0]                    exp_last;
  logic [NumPorts-1:0]                    exp_gnt;
  logic [NumPorts-1:0]                    exp_out_v;
  logic [NumPorts-1:0][NumPortsWidth-1:0] exp_sel;

  int checks;
  int errors;
  int test_checks;
  int test_errors;

  floo_switch_alloc i_floo_switch_alloc (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .vc_head_v_i    (vc_head_v_i),
    .vc_head_i      (vc_head_i),
    .out_ready_i    (out_ready_i),
    .in_gnt_o       (in_gnt_o),
    .in_gnt_vc_id_o (in_gnt_vc_id_o),
    .out_v_o        (out_v_o),
    .out_sel_in_o   (out_sel_in_o)
  );

  // 4 ns period
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // vc index only matters for a granted input
  task automatic check_in_grant(input int port, input logic exp_g,
                                input logic [NumVCWidth-1:0] exp_id);
    checks++;
    if (in_gnt_o[port] !== exp_g) begin
      errors++;
      $display("mismatch at %0t: input %0d grant %b, expected %b",
               $time, port, in_gnt_o[port], exp_g);
    end else if (exp_g && (in_gnt_vc_id_o[port] !== exp_id)) begin
      errors++;
      $display("mismatch at %0t: input %0d vc %0d, expected %0d",
               $time, port, in_gnt_vc_id_o[port], exp_id);
    end
  endtask

  task automatic check_out_sel(input int port, input logic exp_ov,
                               input logic [NumPortsWidth-1:0] exp_in);
    checks++;
    if (out_v_o[port] !== exp_ov) begin
      errors++;
      $display("mismatch at %0t: output %0d valid %b, expected %b",
               $time, port, out_v_o[port], exp_ov);
    end else if (exp_ov && (out_sel_in_o[port] !== exp_in)) begin
      errors++;
      $display("mismatch at %0t: output %0d selects input %0d, expected %0d",
               $time, port, out_sel_in_o[port], exp_in);
    end
  endtask

  // model both stages at the falling edge and compare everything
  task automatic settle();
    int unsigned idx;
    int unsigned src;
    @(negedge clk_i);
    for (int i = 0; i < NumPorts; i++) begin
      exp_v[i]  = 1'b0;
      exp_vc[i] = '0;
      for (int k = 0; k < NumVC; k++) begin
        idx = (lptr[i] + k) % NumVC;
        if (!exp_v[i] && vc_head_v_i[i][idx]) begin
          exp_v[i]  = 1'b1;
          exp_vc[i] = NumVCWidth'(idx);
        end
      end
      exp_last[i] = vc_head_i[i][exp_vc[i]].last;
    end
    exp_gnt = '0;
    for (int o = 0; o < NumPorts; o++) begin
      exp_out_v[o] = 1'b0;
      exp_sel[o]   = '0;
      // first ready requester at or after the output pointer
      for (int k = 0; k < NumPorts; k++) begin
        src = (gptr[o] + k) % NumPorts;
        if (!exp_out_v[o] && out_ready_i[o] && exp_v[src] &&
            (int'(vc_head_i[src][exp_vc[src]].lookahead) == o)) begin
          exp_out_v[o] = 1'b1;
          exp_sel[o]   = NumPortsWidth'(src);
          exp_gnt[src] = 1'b1;
        end
      end
    end
    for (int i = 0; i < NumPorts; i++) begin
      check_in_grant(i, exp_gnt[i], exp_vc[i]);
    end
    for (int o = 0; o < NumPorts; o++) begin
      check_out_sel(o, exp_out_v[o], exp_sel[o]);
    end
  endtask

  // pointers pass the winner at the rising edge, and only on a tail
  task automatic advance();
    @(posedge clk_i);
    for (int i = 0; i < NumPorts; i++) begin
      if (exp_gnt[i] && exp_last[i]) begin
        lptr[i] = (int'(exp_vc[i]) + 1) % NumVC;
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      if (exp_out_v[o] && exp_last[exp_sel[o]]) begin
        gptr[o] = (int'(exp_sel[o]) + 1) % NumPorts;
      end
    end
    // inputs change 1 ns after the edge
    #1;
  endtask

  task automatic cycle();
    settle();
    advance();
  endtask

  // run cycles until the input is granted or the limit is reached
  task automatic wait_in_grant(input int port, input int limit);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && (n < limit)) begin
      settle();
      seen = in_gnt_o[port];
      advance();
      n++;
    end
    if (!seen) begin
      errors++;
      $display("timeout: input %0d got no grant within %0d cycles", port, limit);
    end
  endtask

  task automatic clear_inputs();
    vc_head_v_i = '0;
    vc_head_i   = '0;
    out_ready_i = '1;
  endtask

  task automatic set_head(input int port, input int vc, input route_dir_e dir,
                          input logic last);
    vc_head_v_i[port][vc]         = 1'b1;
    vc_head_i[port][vc].lookahead = dir;
    vc_head_i[port][vc].last      = last;
    vc_head_i[port][vc].dst_id    = DstIdWidth'(port);
  endtask

  // two cycles of reset and one idle cycle so grants start from zero
  task automatic do_reset();
    clear_inputs();
    arst_n_i = 1'b0;
    for (int i = 0; i < NumPorts; i++) begin
      lptr[i] = 0;
      gptr[i] = 0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    cycle();
  endtask

  task automatic end_test(input string name);
    $display("test %-12s done: %0d checks, %0d errors", name,
             checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  initial begin
    int vc;
    int seq [3];
    arst_n_i = 1'b0;
    clear_inputs();
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;
    void'($urandom(32'h16f0_70bd));

    // idle after reset and a lone head per input going straight through
    do_reset();
    repeat (3) cycle();
    for (int i = 0; i < NumPorts; i++) begin
      clear_inputs();
      vc = $urandom_range(0, NumVC - 1);
      set_head(i, vc, route_dir_e'((i + 2) % NumPorts), 1'b1);
      settle();
      check_in_grant(i, 1'b1, NumVCWidth'(vc));
      check_out_sel((i + 2) % NumPorts, 1'b1, NumPortsWidth'(i));
      advance();
    end
    end_test("reset_idle");

    // all vcs of input 2 hold tails so the vc grant walks 0..3 and wraps
    do_reset();
    for (int v = 0; v < NumVC; v++) begin
      set_head(2, v, East, 1'b1);
    end
    for (int k = 0; k < 5; k++) begin
      settle();
      check_in_grant(2, 1'b1, NumVCWidth'(k % NumVC));
      advance();
    end
    end_test("local_rr");

    // inputs 0, 1 and 3 fight for south
    do_reset();
    seq = '{0, 1, 3};
    set_head(0, 0, South, 1'b1);
    set_head(1, 0, South, 1'b1);
    set_head(3, 0, South, 1'b1);
    for (int k = 0; k < 6; k++) begin
      settle();
      check_out_sel(South, 1'b1, NumPortsWidth'(seq[k % 3]));
      advance();
    end
    end_test("global_rr");

    // body flits keep input 1 vc 0 on west until its tail
    do_reset();
    set_head(1, 0, West, 1'b0);
    set_head(1, 2, West, 1'b0);
    set_head(4, 1, West, 1'b0);
    repeat (3) begin
      settle();
      check_in_grant(1, 1'b1, '0);
      check_out_sel(West, 1'b1, NumPortsWidth'(1));
      advance();
    end
    vc_head_i[1][0].last = 1'b1;
    cycle();
    vc_head_i[1][0].last = 1'b0;
    // west now prefers input 4
    settle();
    check_out_sel(West, 1'b1, NumPortsWidth'(4));
    check_in_grant(1, 1'b0, '0);
    advance();
    // once input 4 sends its tail, input 1 comes back on vc 2
    vc_head_i[4][1].last = 1'b1;
    cycle();
    settle();
    check_out_sel(West, 1'b1, NumPortsWidth'(1));
    check_in_grant(1, 1'b1, NumVCWidth'(2));
    advance();
    end_test("wormhole");

    // input 0 wins north once and north then blocks for three cycles
    do_reset();
    set_head(0, 0, North, 1'b1);
    set_head(2, 3, North, 1'b1);
    cycle();
    out_ready_i[North] = 1'b0;
    repeat (3) begin
      settle();
      check_out_sel(North, 1'b0, '0);
      check_in_grant(2, 1'b0, '0);
      advance();
    end
    out_ready_i[North] = 1'b1;
    // priority stayed with input 2
    wait_in_grant(2, 4);
    end_test("backpressure");

    // random valids, headers and ready levels
    for (int n = 0; n < 400; n++) begin
      for (int i = 0; i < NumPorts; i++) begin
        for (int v = 0; v < NumVC; v++) begin
          vc_head_v_i[i][v]         = ($urandom_range(0, 1) == 1);
          vc_head_i[i][v].lookahead = route_dir_e'($urandom_range(0, NumPorts - 1));
          vc_head_i[i][v].last      = ($urandom_range(0, 2) == 0);
          vc_head_i[i][v].dst_id    = DstIdWidth'($urandom);
        end
        out_ready_i[i] = ($urandom_range(0, 3) != 0);
      end
      cycle();
    end
    end_test("random");

    $display("all tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
logic/floo_flit_pkg.sv
logic/floo_sa_pkg.sv
logic/floo_rr_arbiter.sv
logic/floo_mux.sv
logic/floo_sa_if.sv
logic/floo_sa_local.sv
logic/floo_sa_global.sv
logic/floo_switch_alloc.sv
bench/floo_switch_alloc_props.sv
bench/tb_floo_switch_alloc.sv

/* Bender.yml */
package:
  name: floo_switch_alloc

sources:
  # packages first, then leaf modules up to the top level
  - files:
      - logic/floo_flit_pkg.sv
      - logic/floo_sa_pkg.sv
      - logic/floo_rr_arbiter.sv
      - logic/floo_mux.sv
      - logic/floo_sa_if.sv
      - logic/floo_sa_local.sv
      - logic/floo_sa_global.sv
      - logic/floo_switch_alloc.sv

  # simulation only
  - target: test
    files:
      - bench/floo_switch_alloc_props.sv
      - bench/tb_floo_switch_alloc.sv
